//--- build.f
+incdir+.
vec_pkg.sv
sum_squares.sv
invsqrt_rom.sv
inv_sqrt.sv
vec_scale.sv
vec_normalizer.sv
vec_normalizer_props.sv
vec_normalizer_tb.sv

//--- Makefile
TOP = vec_normalizer_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- vec_normalizer_tb.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_normalizer_tb
    import vec_pkg::*;
();

    localparam int CLS_UNIT = 0;
    localparam int CLS_RANGE = 1;
    localparam int CLS_ZERO = 2;
    localparam int CLS_HOLD = 3;
    localparam int CLS_RANDOM = 4;
    localparam int NUM_ENTRIES = 27;
    localparam int NUM_RANDOM = 60;
    localparam int CYCLE_LIMIT = 40 * (NUM_ENTRIES + NUM_RANDOM) + 2000;
    localparam real ONE_Q = 16777216.0;
    localparam real COMP_TOL = 1.0 / 512.0;
    localparam real INV_TOL = 1.0 / 256.0;

    logic clk;
    logic rst;
    logic in_req;
    logic in_ack;
    fp in_x;
    fp in_y;
    fp in_z;
    logic out_req;
    logic out_ack;
    fp out_x;
    fp out_y;
    fp out_z;
    fp out_inv_norm;

    // axis and power-of-four sums first, then the encoder range, the zero vector and a held burst
    real tab_x [NUM_ENTRIES] = '{1.0, 0.0, 0.0, -0.5, 0.0, 0.0, 0.5,
        0.0078125, 0.01, 0.03, 0.1, -0.3, 1.5, 3.0, -6.0, 7.0, 0.0,
        0.25, 1.0, -0.125, 2.5, 0.05, -4.0, 0.3, 6.0, 0.015, 1.25};
    real tab_y [NUM_ENTRIES] = '{0.0, -1.0, 0.0, 0.0, 4.0, 0.0, -0.5,
        0.0078125, -0.004, 0.02, -0.2, 0.4, -2.0, 4.0, 5.0, -5.0, 0.0,
        0.5, -2.0, 0.0625, 2.5, 0.02, 1.0, -0.3, 0.0, -0.02, 3.5};
    real tab_z [NUM_ENTRIES] = '{0.0, 0.0, 2.0, 0.0, 0.0, -8.0, 0.70710678,
        0.0, 0.006, -0.01, 0.05, 0.6, 0.75, 5.0, 5.5, 4.5, 0.0,
        -0.75, 3.0, 0.5, -2.5, 0.01, 2.0, 0.3, -1.0, 0.0, -0.5};
    int tab_cls [NUM_ENTRIES] = '{CLS_UNIT, CLS_UNIT, CLS_UNIT, CLS_UNIT, CLS_UNIT,
        CLS_UNIT, CLS_UNIT, CLS_RANGE, CLS_RANGE, CLS_RANGE, CLS_RANGE, CLS_RANGE,
        CLS_RANGE, CLS_RANGE, CLS_RANGE, CLS_RANGE, CLS_ZERO, CLS_HOLD, CLS_HOLD,
        CLS_HOLD, CLS_HOLD, CLS_HOLD, CLS_HOLD, CLS_HOLD, CLS_HOLD, CLS_HOLD, CLS_HOLD};

    fp rnd_x [NUM_RANDOM];
    fp rnd_y [NUM_RANDOM];
    fp rnd_z [NUM_RANDOM];

    // vectors sent and not yet seen at the output in send order
    fp sent_x [$];
    fp sent_y [$];
    fp sent_z [$];
    int sent_cls [$];

    int seed = 39;
    int total_sent = 0;
    int results_checked = 0;
    int cycle_count = 0;
    int held;
    logic hold_ack;
    logic random_ack;
    int unsigned delay;

    vec_normalizer vec_normalizer_inst (
        .clk(clk),
        .rst(rst),
        .in_req(in_req),
        .in_ack(in_ack),
        .in_x(in_x),
        .in_y(in_y),
        .in_z(in_z),
        .out_req(out_req),
        .out_ack(out_ack),
        .out_x(out_x),
        .out_y(out_y),
        .out_z(out_z),
        .out_inv_norm(out_inv_norm)
    );

    bind vec_normalizer vec_normalizer_props props_inst (
        .clk(clk),
        .rst(rst),
        .in_req(in_req),
        .in_ack(in_ack),
        .out_req(out_req),
        .out_ack(out_ack),
        .out_x(out_x),
        .out_y(out_y),
        .out_z(out_z),
        .out_inv_norm(out_inv_norm)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic fp to_fp(input real r);
        return fp'($rtoi(r * ONE_Q));
    endfunction

    function automatic real to_real(input fp v);
        return $itor(v) / ONE_Q;
    endfunction

    // square truncated to the middle word of the 64-bit product
    function automatic fp square_trunc(input fp v);
        longint full;
        full = longint'(v) * longint'(v);
        return fp'(full >>> `FRAC_BITS);
    endfunction

    function automatic real mag_sq(input fp x, input fp y, input fp z);
        return to_real(x) * to_real(x) + to_real(y) * to_real(y) + to_real(z) * to_real(z);
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_component(input fp got, input real expected, input string name);
        real diff;
        diff = to_real(got) - expected;
        if (diff < 0.0) begin
            diff = -diff;
        end
        if (diff > COMP_TOL) begin
            stop_run($sformatf("** Error at time %0t: %s is %f, expected %f",
                $time, name, to_real(got), expected));
        end
    endtask

    task automatic check_inv_norm(input fp got, input real expected);
        real rel;
        rel = (to_real(got) - expected) / expected;
        if (rel < 0.0) begin
            rel = -rel;
        end
        if (rel > INV_TOL) begin
            stop_run($sformatf("** Error at time %0t: out_inv_norm is %f, expected %f",
                $time, to_real(got), expected));
        end
    endtask

    // compare the output head against the oldest vector sent
    task automatic check_result();
        fp ix;
        fp iy;
        fp iz;
        int cls;
        real norm;
        real sum;
        if (sent_x.size() == 0) begin
            stop_run("a result came out while no vector was waiting for one");
        end
        ix = sent_x.pop_front();
        iy = sent_y.pop_front();
        iz = sent_z.pop_front();
        cls = sent_cls.pop_front();
        if (cls == CLS_ZERO) begin
            check_component(out_x, 0.0, "out_x");
            check_component(out_y, 0.0, "out_y");
            check_component(out_z, 0.0, "out_z");
        end else begin
            norm = $sqrt(mag_sq(ix, iy, iz));
            check_component(out_x, to_real(ix) / norm, "out_x");
            check_component(out_y, to_real(iy) / norm, "out_y");
            check_component(out_z, to_real(iz) / norm, "out_z");
            sum = to_real(square_trunc(ix)) + to_real(square_trunc(iy))
                + to_real(square_trunc(iz));
            check_inv_norm(out_inv_norm, 1.0 / $sqrt(sum));
        end
        results_checked++;
    endtask

    task automatic start_vector(input fp x, input fp y, input fp z, input int cls);
        sent_x.push_back(x);
        sent_y.push_back(y);
        sent_z.push_back(z);
        sent_cls.push_back(cls);
        total_sent++;
        in_x = x;
        in_y = y;
        in_z = z;
        in_req = 1'b1;
    endtask

    task automatic finish_vector();
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
    endtask

    task automatic wait_drained();
        while (results_checked != total_sent) begin
            @(posedge clk);
            #1;
        end
    endtask

    // the sink acks each result after checking it
    initial begin
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_req && !hold_ack) begin
                if (random_ack) begin
                    delay = $unsigned($random(seed)) % 4;
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                end
                check_result();
                out_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (out_req);
                out_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_run($sformatf("timeout: the run did not finish within %0d cycles",
                CYCLE_LIMIT));
        end
    end

    // source side
    initial begin
        rst = 1'b0;
        in_req = 1'b0;
        in_x = '0;
        in_y = '0;
        in_z = '0;
        hold_ack = 1'b0;
        random_ack = 1'b0;
        held = 0;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_x[i] = fp'($random(seed) >>> 5);
            rnd_y[i] = fp'($random(seed) >>> 5);
            rnd_z[i] = fp'($random(seed) >>> 5);
            // keep the sum of squares inside the encoder range
            if (mag_sq(rnd_x[i], rnd_y[i], rnd_z[i]) < 1.0 / 4096.0) begin
                rnd_x[i] = to_fp(1.0);
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (4) begin
            @(posedge clk);
            #1;
            if (in_ack !== 1'b0 || out_req !== 1'b0) begin
                stop_run($sformatf("** Error at time %0t: handshake active with no request",
                    $time));
            end
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (tab_cls[i] != CLS_HOLD) begin
                start_vector(to_fp(tab_x[i]), to_fp(tab_y[i]), to_fp(tab_z[i]), tab_cls[i]);
                finish_vector();
            end
        end
        wait_drained();
        // with the sink stalled only QUEUE_DEPTH vectors fit before credit runs out
        hold_ack = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (tab_cls[i] == CLS_HOLD) begin
                start_vector(to_fp(tab_x[i]), to_fp(tab_y[i]), to_fp(tab_z[i]), tab_cls[i]);
                if (held == `QUEUE_DEPTH) begin
                    repeat (4 * `PIPE_LATENCY) begin
                        @(posedge clk);
                        #1;
                        if (in_ack) begin
                            stop_run($sformatf(
                                "** Error at time %0t: in_ack beyond %0d held results",
                                $time, `QUEUE_DEPTH));
                        end
                    end
                    hold_ack = 1'b0;
                end
                finish_vector();
                held++;
            end
        end
        wait_drained();
        random_ack = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            start_vector(rnd_x[i], rnd_y[i], rnd_z[i], CLS_RANDOM);
            finish_vector();
        end
        wait_drained();
        repeat (2 * `PIPE_LATENCY) @(posedge clk);
        #1;
        if (out_req) begin
            stop_run("an extra result appeared after the last vector was checked");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- vec_normalizer_props.sv
`timescale 1ns/1ps

module vec_normalizer_props
    import vec_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic in_req,
    input logic in_ack,
    input logic out_req,
    input logic out_ack,
    input fp    out_x,
    input fp    out_y,
    input fp    out_z,
    input fp    out_inv_norm
);

    // in_ack answers a request seen on the previous edge
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    req_drops_after_ack: assert property (@(posedge clk) disable iff (!rst)
        $fell(out_req) |-> $past(out_ack))
        else $error("out_req fell before out_ack");

    // head data holds for the whole request
    data_held: assert property (@(posedge clk) disable iff (!rst)
        out_req && $past(out_req) |-> $stable(out_x) && $stable(out_y)
            && $stable(out_z) && $stable(out_inv_norm))
        else $error("output data changed while out_req was high");

    req_waits_for_ack_low: assert property (@(posedge clk) disable iff (!rst)
        $rose(out_req) |-> !$past(out_ack))
        else $error("out_req rose while out_ack was high");

endmodule

//--- vec_normalizer.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_normalizer
    import vec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic in_req,
    output logic in_ack,
    input  fp    in_x,
    input  fp    in_y,
    input  fp    in_z,
    output logic out_req,
    input  logic out_ack,
    output fp    out_x,
    output fp    out_y,
    output fp    out_z,
    output fp    out_inv_norm
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int FLIGHT_W = $clog2(`PIPE_LATENCY + 1);
    localparam int CNT_W = PTR_W + 2;

    logic accept;
    logic ss_valid;
    fp sum_sq;
    fp inv_norm;
    logic sc_valid;
    fp sc_x;
    fp sc_y;
    fp sc_z;
    fp sc_inv;

    logic [FLIGHT_W-1:0] in_flight;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] q_count;
    logic [CNT_W-1:0] pending;
    logic credit;
    logic push;
    logic pop;

    fp q_x [`QUEUE_DEPTH];
    fp q_y [`QUEUE_DEPTH];
    fp q_z [`QUEUE_DEPTH];
    fp q_inv [`QUEUE_DEPTH];

    // a vector is taken only if a queue slot is already reserved for it
    assign pending = CNT_W'(q_count) + CNT_W'(in_flight);
    assign credit = pending < CNT_W'(`QUEUE_DEPTH);
    assign accept = in_req && !in_ack && credit;
    assign push = sc_valid;
    assign pop = out_req && out_ack;

    sum_squares sum_squares_inst (
        .clk(clk),
        .rst(rst),
        .valid_in(accept),
        .x(in_x),
        .y(in_y),
        .z(in_z),
        .valid_out(ss_valid),
        .sum_sq(sum_sq)
    );

    // vec_scale carries its own valid down the component line
    inv_sqrt inv_sqrt_inst (
        .clk(clk),
        .rst(rst),
        .valid_in(ss_valid),
        .x(sum_sq),
        .valid_out(),
        .inv_sqrt(inv_norm)
    );

    vec_scale vec_scale_inst (
        .clk(clk),
        .rst(rst),
        .valid_in(accept),
        .x(in_x),
        .y(in_y),
        .z(in_z),
        .inv_norm(inv_norm),
        .valid_out(sc_valid),
        .nx(sc_x),
        .ny(sc_y),
        .nz(sc_z),
        .inv_norm_out(sc_inv)
    );

    // handshakes, in-flight count and queue pointers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            in_ack <= 1'b0;
            out_req <= 1'b0;
            in_flight <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
        end else begin
            if (in_ack) begin
                if (!in_req) begin
                    in_ack <= 1'b0;
                end
            end else if (accept) begin
                in_ack <= 1'b1;
            end

            case ({accept, push})
                2'b10: in_flight <= in_flight + 1'b1;
                2'b01: in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase

            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: q_count <= q_count + 1'b1;
                2'b01: q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase

            // return to zero needs the sink to drop ack first
            if (out_req) begin
                if (out_ack) begin
                    out_req <= 1'b0;
                end
            end else if (!out_ack && q_count != '0) begin
                out_req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_x[wr_ptr] <= sc_x;
            q_y[wr_ptr] <= sc_y;
            q_z[wr_ptr] <= sc_z;
            q_inv[wr_ptr] <= sc_inv;
        end
    end

    // head slot, held until the pop
    assign out_x = q_x[rd_ptr];
    assign out_y = q_y[rd_ptr];
    assign out_z = q_z[rd_ptr];
    assign out_inv_norm = q_inv[rd_ptr];

endmodule

//--- vec_scale.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module vec_scale
    import vec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    input  fp    x,
    input  fp    y,
    input  fp    z,
    input  fp    inv_norm,
    output logic valid_out,
    output fp    nx,
    output fp    ny,
    output fp    nz,
    output fp    inv_norm_out
);

    // components wait here while the inverse norm is computed
    localparam int LINE_DEPTH = `PIPE_LATENCY - 1;

    fp line_x [LINE_DEPTH];
    fp line_y [LINE_DEPTH];
    fp line_z [LINE_DEPTH];
    logic [LINE_DEPTH-1:0] line_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_valid <= '0;
            valid_out <= 1'b0;
        end else begin
            line_valid <= {line_valid[LINE_DEPTH-2:0], valid_in};
            valid_out <= line_valid[LINE_DEPTH-1];
        end
    end

    // shifts every cycle, several vectors can be in the line at once
    always_ff @(posedge clk) begin
        line_x[0] <= x;
        line_y[0] <= y;
        line_z[0] <= z;
        for (int i = 1; i < LINE_DEPTH; i++) begin
            line_x[i] <= line_x[i-1];
            line_y[i] <= line_y[i-1];
            line_z[i] <= line_z[i-1];
        end
    end

    // the last line slot lines up with the inverse norm of the same vector
    always_ff @(posedge clk) begin
        if (line_valid[LINE_DEPTH-1]) begin
            nx <= fp_mul(line_x[LINE_DEPTH-1], inv_norm);
            ny <= fp_mul(line_y[LINE_DEPTH-1], inv_norm);
            nz <= fp_mul(line_z[LINE_DEPTH-1], inv_norm);
            inv_norm_out <= inv_norm;
        end
    end

endmodule

//--- inv_sqrt.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module inv_sqrt
    import vec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    input  fp    x,
    output logic valid_out,
    output fp    inv_sqrt
);

    // the rom holds 1/sqrt scaled down so the product with a large scale stays in range
    localparam int ROM_SHIFT = 6;

    exp_code_t code_next;
    fp norm_next;
    fp scale_next;

    fp norm_x;
    fp scale_s1;
    fp scale_s2;
    logic valid_s1;
    logic valid_s2;
    fp rom_word;

    // priority encoder on the leading one, x lands in [0.5, 1)
    always_comb begin
        casez (x)
            32'b1???_????_????_????_????_????_????_????: code_next = 5'd8;
            32'b01??_????_????_????_????_????_????_????: code_next = 5'd7;
            32'b001?_????_????_????_????_????_????_????: code_next = 5'd6;
            32'b0001_????_????_????_????_????_????_????: code_next = 5'd5;
            32'b0000_1???_????_????_????_????_????_????: code_next = 5'd4;
            32'b0000_01??_????_????_????_????_????_????: code_next = 5'd3;
            32'b0000_001?_????_????_????_????_????_????: code_next = 5'd2;
            32'b0000_0001_????_????_????_????_????_????: code_next = 5'd1;
            32'b0000_0000_1???_????_????_????_????_????: code_next = 5'd0;
            32'b0000_0000_01??_????_????_????_????_????: code_next = 5'd9;
            32'b0000_0000_001?_????_????_????_????_????: code_next = 5'd10;
            32'b0000_0000_0001_????_????_????_????_????: code_next = 5'd11;
            32'b0000_0000_0000_1???_????_????_????_????: code_next = 5'd12;
            32'b0000_0000_0000_01??_????_????_????_????: code_next = 5'd13;
            32'b0000_0000_0000_001?_????_????_????_????: code_next = 5'd14;
            32'b0000_0000_0000_0001_????_????_????_????: code_next = 5'd15;
            32'b0000_0000_0000_0000_1???_????_????_????: code_next = 5'd16;
            32'b0000_0000_0000_0000_01??_????_????_????: code_next = 5'd17;
            32'b0000_0000_0000_0000_001?_????_????_????: code_next = 5'd18;
            32'b0000_0000_0000_0000_0001_????_????_????: code_next = 5'd19;
            32'b0000_0000_0000_0000_0000_1???_????_????: code_next = 5'd20;
            32'b0000_0000_0000_0000_0000_01??_????_????: code_next = 5'd21;
            // zero or below range, passed through unshifted
            default: code_next = 5'd0;
        endcase

        if (code_next <= 5'd8) begin
            norm_next = x >> code_next;
        end else begin
            norm_next = x << (code_next - 5'd8);
        end

        // 2^(shift/2), negative exponent for right shifts
        case (code_next)
            5'd0: scale_next = 32'h0100_0000;
            5'd1: scale_next = 32'h00B5_04F3;
            5'd2: scale_next = 32'h0080_0000;
            5'd3: scale_next = 32'h005A_8279;
            5'd4: scale_next = 32'h0040_0000;
            5'd5: scale_next = 32'h002D_413D;
            5'd6: scale_next = 32'h0020_0000;
            5'd7: scale_next = 32'h0016_A09E;
            5'd8: scale_next = 32'h0010_0000;
            5'd9: scale_next = 32'h016A_09E6;
            5'd10: scale_next = 32'h0200_0000;
            5'd11: scale_next = 32'h02D4_13CD;
            5'd12: scale_next = 32'h0400_0000;
            5'd13: scale_next = 32'h05A8_279A;
            5'd14: scale_next = 32'h0800_0000;
            5'd15: scale_next = 32'h0B50_4F33;
            5'd16: scale_next = 32'h1000_0000;
            5'd17: scale_next = 32'h16A0_9E66;
            5'd18: scale_next = 32'h2000_0000;
            5'd19: scale_next = 32'h2D41_3CCD;
            5'd20: scale_next = 32'h4000_0000;
            5'd21: scale_next = 32'h5A82_799A;
            default: scale_next = 32'h0100_0000;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_s1 <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_s1 <= valid_in;
            valid_out <= valid_s2;
        end
    end

    // normalize register, scale then waits one more cycle for the rom
    always_ff @(posedge clk) begin
        if (valid_in) begin
            norm_x <= norm_next;
            scale_s1 <= scale_next;
        end
        scale_s2 <= scale_s1;
    end

    invsqrt_rom #(
        .DOWN_SHIFT(ROM_SHIFT)
    ) invsqrt_rom_inst (
        .clk(clk),
        .en(valid_s1),
        .in_addr(norm_x[`FRAC_BITS-1 -: `LUT_ADDR_BITS]),
        .out_sqrtinv(rom_word),
        .valid_out(valid_s2)
    );

    // undo the rom scale-down after applying the exponent
    always_ff @(posedge clk) begin
        if (valid_s2) begin
            inv_sqrt <= fp_mul(rom_word, scale_s2) << ROM_SHIFT;
        end
    end

endmodule

//--- invsqrt_rom.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module invsqrt_rom
    import vec_pkg::*;
#(
    // table values are scaled down by 2^DOWN_SHIFT
    parameter int DOWN_SHIFT = 6
)(
    input  logic                      clk,
    input  logic                      en,
    input  logic [`LUT_ADDR_BITS-1:0] in_addr,
    output fp                         out_sqrtinv,
    output logic                      valid_out
);

    localparam int ENTRIES = 2 ** `LUT_ADDR_BITS;

    logic [`WORD_WIDTH-1:0] mem [ENTRIES];

    // entry i covers [i, i+1) / 2^LUT_ADDR_BITS, evaluated at the midpoint
    // only the upper half is reached by a normalized input in [0.5, 1)
    initial begin
        real v;
        real r;
        for (int i = 0; i < ENTRIES; i++) begin
            v = (real'(i) + 0.5) / real'(ENTRIES);
            r = 1.0 / $sqrt(v);
            mem[i] = $rtoi(r * (2.0 ** (`FRAC_BITS - DOWN_SHIFT)) + 0.5);
        end
    end

    // registered read, data and strobe one cycle after en
    always_ff @(posedge clk) begin
        valid_out <= en;
        if (en) begin
            out_sqrtinv <= mem[in_addr];
        end
    end

endmodule

//--- sum_squares.sv
`timescale 1ns/1ps
`include "vec_consts.svh"

module sum_squares
    import vec_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic valid_in,
    input  fp    x,
    input  fp    y,
    input  fp    z,
    output logic valid_out,
    output fp    sum_sq
);

    // squares of each component
    fp sq_x;
    fp sq_y;
    fp sq_z;
    logic sq_valid;

    // valid strobe follows the data through both registers
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sq_valid <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            sq_valid <= valid_in;
            valid_out <= sq_valid;
        end
    end

    // stage a: square each component
    always_ff @(posedge clk) begin
        if (valid_in) begin
            sq_x <= fp_mul(x, x);
            sq_y <= fp_mul(y, y);
            sq_z <= fp_mul(z, z);
        end
    end

    // stage b: add the three squares
    // inputs are limited so the sum stays below 128 and never reaches the sign bit
    always_ff @(posedge clk) begin
        if (sq_valid) begin
            sum_sq <= sq_x + sq_y + sq_z;
        end
    end

endmodule

//--- vec_pkg.sv
`include "vec_consts.svh"

package vec_pkg;

    // Q8.24 word, components signed, sum of squares and inverse norm non-negative
    typedef logic signed [`WORD_WIDTH-1:0] fp;

    // normalizer shift code
    // 0..8 are right shifts, 9..21 are left shifts by (code - 8)
    typedef logic [4:0] exp_code_t;

    // signed Q8.24 product, keeps the middle word of the full product
    function automatic fp fp_mul(input fp a, input fp b);
        logic signed [2*`WORD_WIDTH-1:0] prod;
        prod = a * b;
        return prod[`FRAC_BITS +: `WORD_WIDTH];
    endfunction

endpackage

//--- vec_consts.svh
`ifndef VEC_CONSTS_SVH
`define VEC_CONSTS_SVH

// fixed-point word, Q8.24
`define WORD_WIDTH 32
`define FRAC_BITS 24

// lookup address, taken from the top fraction bits of the normalized value
`define LUT_ADDR_BITS 12

// result slots held at the top level
`define QUEUE_DEPTH 8

// cycles from the accept edge to the queue write
`define PIPE_LATENCY 6

`endif
